/* rtl/rx_intf_pkg.sv */
// rx interface package with widths, buffer sizing, header type and info word layout
package rx_intf_pkg;

    // stream and decoder widths
    localparam int word_w         = 64;
    localparam int byte_w         = 8;
    localparam int bytes_per_word = 8;
    localparam int lane_w         = 3;
    localparam int len_w          = 16;
    localparam int rate_w         = 8;
    localparam int rssi_w         = 11;
    localparam int tsf_w          = 64;
    localparam int sn_w           = 16;

    // packet buffer in words, pointers carry one wrap bit
    localparam int buf_depth  = 1024;
    localparam int buf_addr_w = 10;
    localparam int ptr_w      = buf_addr_w + 1;

    // end addresses of committed frames
    localparam int endq_depth  = 32;
    localparam int endq_addr_w = 5;

    // info word field positions
    // all other info bits are zero
    localparam int info_len_lsb  = 0;
    localparam int info_rate_lsb = 16;
    localparam int info_rssi_lsb = 24;
    localparam int info_fcs_bit  = 40;
    localparam int info_sn_lsb   = 48;

    typedef struct packed {
        logic [len_w-1:0]  len;
        logic [rate_w-1:0] rate;
        logic [rssi_w-1:0] rssi;
        logic [tsf_w-1:0]  tsf;
    } rx_hdr_t;

endpackage

/* rtl/rx_byte_if.sv */
// byte interface carrying decoded bytes and packet events from capture to packer
`timescale 1ns/1ps

interface rx_byte_if;
    import rx_intf_pkg::*;

    // packet opened, header valid with it
    logic              start;
    rx_hdr_t           hdr;
    // one payload byte per strobe
    logic [byte_w-1:0] byte_val;
    logic              byte_strobe;
    // fcs result closes the packet
    logic              fcs_strobe;
    logic              fcs_ok;

    modport capture (
        output start, hdr,
        output byte_val, byte_strobe,
        output fcs_strobe, fcs_ok
    );

    modport packer (
        input start, hdr,
        input byte_val, byte_strobe,
        input fcs_strobe, fcs_ok
    );

endinterface

/* rtl/rx_word_if.sv */
// word interface carrying packed words and packet events from packer to buffer
`timescale 1ns/1ps

interface rx_word_if;
    import rx_intf_pkg::*;

    // header of the new packet
    logic              hdr_strobe;
    rx_hdr_t           hdr;
    // packed payload word
    logic [word_w-1:0] word;
    logic              word_strobe;
    // end of packet with fcs result
    logic              end_strobe;
    logic              end_ok;

    modport packer (
        output hdr_strobe, hdr,
        output word, word_strobe,
        output end_strobe, end_ok
    );

    modport buffer (
        input hdr_strobe, hdr,
        input word, word_strobe,
        input end_strobe, end_ok
    );

endinterface

/* rtl/rx_event_capture.sv */
// event capture stage, qualifies decoder strobes and latches the packet header
`timescale 1ns/1ps

module rx_event_capture (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              pkt_header_valid_strobe,
    input  logic                              pkt_header_valid,
    input  logic                              ht_unsupport,
    input  logic [rx_intf_pkg::rate_w-1:0]    pkt_rate,
    input  logic [rx_intf_pkg::len_w-1:0]     pkt_len,
    input  logic [rx_intf_pkg::rssi_w-1:0]    rssi_half_db,
    input  logic [rx_intf_pkg::tsf_w-1:0]     tsf_runtime_val,
    input  logic [rx_intf_pkg::byte_w-1:0]    byte_in,
    input  logic                              byte_in_strobe,
    input  logic                              fcs_in_strobe,
    input  logic                              fcs_ok,
    rx_byte_if.capture                        byte_bus
);
    import rx_intf_pkg::*;

    logic pkt_open;
    logic hdr_accept;

    // ht frames are not decoded, so they never open a packet
    assign hdr_accept = pkt_header_valid_strobe && pkt_header_valid && !ht_unsupport;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pkt_open             <= 1'b0;
            byte_bus.start       <= 1'b0;
            byte_bus.byte_strobe <= 1'b0;
            byte_bus.fcs_strobe  <= 1'b0;
        end
        else
        begin
            byte_bus.start       <= hdr_accept;
            byte_bus.byte_strobe <= byte_in_strobe && pkt_open;
            byte_bus.fcs_strobe  <= fcs_in_strobe && pkt_open;
            // any header strobe ends the old packet
            if (pkt_header_valid_strobe)
                pkt_open <= hdr_accept;
            else if (fcs_in_strobe)
                pkt_open <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (hdr_accept)
        begin
            byte_bus.hdr.len  <= pkt_len;
            byte_bus.hdr.rate <= pkt_rate;
            byte_bus.hdr.rssi <= rssi_half_db;
            byte_bus.hdr.tsf  <= tsf_runtime_val;
        end
        byte_bus.byte_val <= byte_in;
        byte_bus.fcs_ok   <= fcs_ok;
    end

    // decoder never reports fcs while still delivering bytes
    a_fcs_not_with_byte: assert property (
        @(posedge clk) disable iff (reset) !(fcs_in_strobe && byte_in_strobe)
    );

endmodule

/* rtl/byte_packer.sv */
// byte packer stage, packs payload bytes into little-endian 64-bit words
`timescale 1ns/1ps

module byte_packer (
    input  logic      clk,
    input  logic      reset,
    rx_byte_if.packer byte_bus,
    rx_word_if.packer word_bus
);
    import rx_intf_pkg::*;

    logic [len_w-1:0]  count;
    logic [len_w-1:0]  len_q;
    logic [word_w-1:0] shreg;
    logic [word_w-1:0] merged;
    logic              byte_take;
    logic              word_done;

    // bytes past the header length are dropped
    assign byte_take = byte_bus.byte_strobe && (count < len_q);

    // top lane filled or final byte of the packet
    assign word_done = (count[lane_w-1:0] == lane_w'(bytes_per_word - 1)) ||
                       ((count + len_w'(1)) == len_q);

    always_comb
    begin
        merged = shreg;
        merged[count[lane_w-1:0]*byte_w +: byte_w] = byte_bus.byte_val;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count                <= '0;
            len_q                <= '0;
            word_bus.hdr_strobe  <= 1'b0;
            word_bus.word_strobe <= 1'b0;
            word_bus.end_strobe  <= 1'b0;
        end
        else
        begin
            word_bus.hdr_strobe  <= byte_bus.start;
            word_bus.word_strobe <= byte_take && word_done;
            word_bus.end_strobe  <= byte_bus.fcs_strobe;
            if (byte_bus.start)
            begin
                count <= '0;
                len_q <= byte_bus.hdr.len;
            end
            else if (byte_take)
                count <= count + len_w'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        // partial words leave the upper lanes at zero
        if (byte_bus.start)
            shreg <= '0;
        else if (byte_take)
            shreg <= word_done ? '0 : merged;
        if (byte_take && word_done)
            word_bus.word <= merged;
        if (byte_bus.start)
            word_bus.hdr <= byte_bus.hdr;
        word_bus.end_ok <= byte_bus.fcs_ok;
    end

    // a single packet must fit into the frame buffer
    a_count_in_capacity: assert property (
        @(posedge clk) disable iff (reset) count <= len_w'(buf_depth * bytes_per_word)
    );

endmodule

/* rtl/frame_buffer.sv */
// frame buffer stage, stores packets until their fcs result and serves committed frames
`timescale 1ns/1ps

module frame_buffer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pass_bad_fcs,
    rx_word_if.buffer                      word_bus,
    output logic [rx_intf_pkg::word_w-1:0] data,
    output logic                           last,
    output logic                           valid,
    input  logic                           take
);
    import rx_intf_pkg::*;

    logic [word_w-1:0]     mem [buf_depth];
    logic [ptr_w-1:0]      endq [endq_depth];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      commit_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [ptr_w-1:0]      stored_cnt;
    logic [ptr_w-1:0]      wr_cnt;
    logic [endq_addr_w:0]  endq_wr;
    logic [endq_addr_w:0]  endq_rd;
    logic                  endq_full;
    rx_hdr_t               hdr_q;
    logic [sn_w-1:0]       sn;
    logic                  pkt_active;
    logic                  ovf;
    logic                  hdr_fits;
    logic                  word_fits;
    logic                  pkt_end;
    logic                  commit;
    logic [word_w-1:0]     info;
    logic                  mem_we;
    logic [buf_addr_w-1:0] mem_addr;
    logic [word_w-1:0]     mem_din;
    logic                  avail;
    logic                  load;
    logic                  at_end;

    assign stored_cnt = commit_ptr - rd_ptr;
    assign wr_cnt     = wr_ptr - rd_ptr;
    assign hdr_fits   = stored_cnt <= ptr_w'(buf_depth - 2);
    assign word_fits  = wr_cnt < ptr_w'(buf_depth);
    assign endq_full  = (endq_wr[endq_addr_w] != endq_rd[endq_addr_w]) &&
                        (endq_wr[endq_addr_w-1:0] == endq_rd[endq_addr_w-1:0]);

    assign pkt_end = word_bus.end_strobe && pkt_active;
    assign commit  = pkt_end && !ovf && !endq_full && (word_bus.end_ok || pass_bad_fcs);

    always_comb
    begin
        info = '0;
        info[info_len_lsb +: len_w]   = hdr_q.len;
        info[info_rate_lsb +: rate_w] = hdr_q.rate;
        info[info_rssi_lsb +: rssi_w] = hdr_q.rssi;
        info[info_fcs_bit]            = word_bus.end_ok;
        info[info_sn_lsb +: sn_w]     = sn;
    end

    // one write per cycle: tsf slot, info slot or payload
    always_comb
    begin
        mem_we   = 1'b0;
        mem_addr = wr_ptr[buf_addr_w-1:0];
        mem_din  = word_bus.word;
        if (word_bus.hdr_strobe)
        begin
            mem_we   = hdr_fits;
            mem_addr = commit_ptr[buf_addr_w-1:0];
            mem_din  = word_bus.hdr.tsf;
        end
        else if (pkt_end)
        begin
            mem_we   = !ovf;
            mem_addr = commit_ptr[buf_addr_w-1:0] + 1'b1;
            mem_din  = info;
        end
        else if (word_bus.word_strobe && pkt_active)
            mem_we = !ovf && word_fits;
    end

    always_ff @(posedge clk)
    begin
        if (mem_we)
            mem[mem_addr] <= mem_din;
        if (word_bus.hdr_strobe)
            hdr_q <= word_bus.hdr;
        if (commit)
            endq[endq_wr[endq_addr_w-1:0]] <= wr_ptr - 1'b1;
    end

    // write side, new packets always start at the committed pointer
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            endq_wr    <= '0;
            sn         <= '0;
            pkt_active <= 1'b0;
            ovf        <= 1'b0;
        end
        else if (word_bus.hdr_strobe)
        begin
            pkt_active <= 1'b1;
            ovf        <= !hdr_fits;
            wr_ptr     <= commit_ptr + ptr_w'(2);
        end
        else if (pkt_end)
        begin
            pkt_active <= 1'b0;
            if (commit)
            begin
                commit_ptr <= wr_ptr;
                endq_wr    <= endq_wr + 1'b1;
                sn         <= sn + 1'b1;
            end
            else
                wr_ptr <= commit_ptr;
        end
        else if (word_bus.word_strobe && pkt_active && !ovf)
        begin
            if (word_fits)
                wr_ptr <= wr_ptr + 1'b1;
            else
                ovf <= 1'b1;
        end
    end

    // read side
    assign avail  = rd_ptr != commit_ptr;
    assign load   = avail && (!valid || take);
    assign at_end = (endq_rd != endq_wr) && (rd_ptr == endq[endq_rd[endq_addr_w-1:0]]);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr  <= '0;
            endq_rd <= '0;
            valid   <= 1'b0;
        end
        else
        begin
            if (!valid || take)
                valid <= avail;
            if (load)
            begin
                rd_ptr <= rd_ptr + 1'b1;
                if (at_end)
                    endq_rd <= endq_rd + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            data <= mem[rd_ptr[buf_addr_w-1:0]];
            last <= at_end;
        end
    end

    // reads stay behind committed data
    a_rd_behind_commit: assert property (
        @(posedge clk) disable iff (reset) stored_cnt <= ptr_w'(buf_depth)
    );

endmodule

/* rtl/stream_out.sv */
// stream output stage, registered word stream with back-pressure and packet interrupt
`timescale 1ns/1ps

module stream_out (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [rx_intf_pkg::word_w-1:0] data,
    input  logic                           last,
    input  logic                           valid,
    output logic                           take,
    output logic [rx_intf_pkg::word_w-1:0] m_axis_tdata,
    output logic                           m_axis_tvalid,
    output logic                           m_axis_tlast,
    input  logic                           m_axis_tready,
    output logic                           rx_pkt_intr
);

    // register is free when empty or when its word leaves this cycle
    assign take = !m_axis_tvalid || m_axis_tready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            m_axis_tvalid <= 1'b0;
            rx_pkt_intr   <= 1'b0;
        end
        else
        begin
            if (take)
                m_axis_tvalid <= valid;
            // pulse once the last word of a frame has gone out
            rx_pkt_intr <= m_axis_tvalid && m_axis_tready && m_axis_tlast;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take && valid)
        begin
            m_axis_tdata <= data;
            m_axis_tlast <= last;
        end
    end

    // sink stall keeps the word in place
    a_tdata_stable: assert property (
        @(posedge clk) disable iff (reset)
        (m_axis_tvalid && !m_axis_tready) |=> $stable(m_axis_tdata)
    );

endmodule

/* rtl/rx_intf_top.sv */
// rx interface top, decoder inputs to framed word stream with packet interrupt
`timescale 1ns/1ps

module rx_intf_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              pkt_header_valid_strobe,
    input  logic                              pkt_header_valid,
    input  logic                              ht_unsupport,
    input  logic [rx_intf_pkg::rate_w-1:0]    pkt_rate,
    input  logic [rx_intf_pkg::len_w-1:0]     pkt_len,
    input  logic [rx_intf_pkg::rssi_w-1:0]    rssi_half_db,
    input  logic [rx_intf_pkg::tsf_w-1:0]     tsf_runtime_val,
    input  logic [rx_intf_pkg::byte_w-1:0]    byte_in,
    input  logic                              byte_in_strobe,
    input  logic                              fcs_in_strobe,
    input  logic                              fcs_ok,
    input  logic                              pass_bad_fcs,
    output logic [rx_intf_pkg::word_w-1:0]    m_axis_tdata,
    output logic                              m_axis_tvalid,
    output logic                              m_axis_tlast,
    input  logic                              m_axis_tready,
    output logic                              rx_pkt_intr
);
    import rx_intf_pkg::*;

    rx_byte_if byte_bus ();
    rx_word_if word_bus ();

    // buffer to output register
    logic [word_w-1:0] fb_data;
    logic              fb_last;
    logic              fb_valid;
    logic              fb_take;

    rx_event_capture u_capture (
        .clk                     (clk),
        .reset                   (reset),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .pkt_header_valid        (pkt_header_valid),
        .ht_unsupport            (ht_unsupport),
        .pkt_rate                (pkt_rate),
        .pkt_len                 (pkt_len),
        .rssi_half_db            (rssi_half_db),
        .tsf_runtime_val         (tsf_runtime_val),
        .byte_in                 (byte_in),
        .byte_in_strobe          (byte_in_strobe),
        .fcs_in_strobe           (fcs_in_strobe),
        .fcs_ok                  (fcs_ok),
        .byte_bus                (byte_bus.capture)
    );

    byte_packer u_packer (
        .clk      (clk),
        .reset    (reset),
        .byte_bus (byte_bus.packer),
        .word_bus (word_bus.packer)
    );

    frame_buffer u_buffer (
        .clk          (clk),
        .reset        (reset),
        .pass_bad_fcs (pass_bad_fcs),
        .word_bus     (word_bus.buffer),
        .data         (fb_data),
        .last         (fb_last),
        .valid        (fb_valid),
        .take         (fb_take)
    );

    stream_out u_stream (
        .clk           (clk),
        .reset         (reset),
        .data          (fb_data),
        .last          (fb_last),
        .valid         (fb_valid),
        .take          (fb_take),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready),
        .rx_pkt_intr   (rx_pkt_intr)
    );

endmodule

/* tests/tb_tasks.svh */
// testbench tasks for packet driving, expected frame building and result checks
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (actual !== expected)
    begin
        err_cnt = err_cnt + 1;
        $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        $display("SOME TESTS FAILED");
        $fatal(1, "check failed");
    end
endtask

// one decoder packet: header strobe, bytes with gaps, then fcs
task automatic send_packet(input int len, input logic [7:0] rate, input logic [10:0] rssi,
                           input logic [63:0] tsf, input logic good, input logic hdr_ok,
                           input logic ht);
    int i;
    @(posedge clk);
    pkt_header_valid_strobe <= 1'b1;
    pkt_header_valid        <= hdr_ok;
    ht_unsupport            <= ht;
    pkt_len                 <= 16'(len);
    pkt_rate                <= rate;
    rssi_half_db            <= rssi;
    tsf_runtime_val         <= tsf;
    @(posedge clk);
    pkt_header_valid_strobe <= 1'b0;
    for (i = 0; i < len; i++)
    begin
        @(posedge clk);
        byte_in        <= pay[i];
        byte_in_strobe <= 1'b1;
        @(posedge clk);
        byte_in_strobe <= 1'b0;
    end
    // fcs well clear of the last byte
    repeat (3) @(posedge clk);
    fcs_in_strobe <= 1'b1;
    fcs_ok        <= good;
    @(posedge clk);
    fcs_in_strobe <= 1'b0;
endtask

// tsf word, info word, then payload little-endian with zero fill
task automatic expect_frame(input int len, input logic [7:0] rate, input logic [10:0] rssi,
                            input logic [63:0] tsf, input logic ok);
    logic [63:0] info;
    logic [63:0] word;
    int          nwords;
    int          w;
    int          b;
    info        = '0;
    info[15:0]  = 16'(len);
    info[23:16] = rate;
    info[34:24] = rssi;
    info[40]    = ok;
    info[63:48] = exp_sn;
    nwords      = (len + 7) / 8;
    exp_q.push_back(tsf);
    exp_last.push_back(1'b0);
    exp_q.push_back(info);
    exp_last.push_back(nwords == 0);
    for (w = 0; w < nwords; w++)
    begin
        word = '0;
        for (b = 0; b < 8; b++)
            if (w * 8 + b < len)
                word[b*8 +: 8] = pay[w * 8 + b];
        exp_q.push_back(word);
        exp_last.push_back(w == nwords - 1);
    end
    exp_sn    = exp_sn + 16'd1;
    frame_cnt = frame_cnt + 1;
endtask

task automatic run_packet(input int len, input logic good, input logic hdr_ok,
                          input logic ht, input logic frame_expected);
    logic [7:0]  rate;
    logic [10:0] rssi;
    logic [63:0] tsf;
    int          i;
    rate = 8'($random(seed));
    rssi = 11'($random(seed));
    tsf  = {32'($random(seed)), 32'($random(seed))};
    for (i = 0; i < len; i++)
        pay[i] = 8'($random(seed));
    if (frame_expected)
        expect_frame(len, rate, rssi, tsf, good);
    send_packet(len, rate, rssi, tsf, good, hdr_ok, ht);
endtask

// waits for every expected word, then compares in order
task automatic check_frames(input string name);
    int          i;
    int          n;
    logic [63:0] exp_word;
    logic [63:0] out_word;
    bit          exp_l;
    bit          out_l;
    n = exp_q.size();
    while (out_q.size() < n)
        @(posedge clk);
    for (i = 0; i < n; i++)
    begin
        exp_word = exp_q.pop_front();
        out_word = out_q.pop_front();
        exp_l    = exp_last.pop_front();
        out_l    = last_q.pop_front();
        check_value($sformatf("%s word %0d data", name, i), exp_word, out_word);
        check_value($sformatf("%s word %0d last", name, i), 64'(exp_l), 64'(out_l));
    end
endtask

task automatic test_good_packets();
    run_packet(1, 1'b1, 1'b1, 1'b0, 1'b1);
    run_packet(8, 1'b1, 1'b1, 1'b0, 1'b1);
    run_packet(13, 1'b1, 1'b1, 1'b0, 1'b1);
    run_packet(100, 1'b1, 1'b1, 1'b0, 1'b1);
    check_frames("good_packets");
endtask

task automatic test_bad_fcs();
    // dropped packet keeps sn, the good one behind it shows that
    run_packet(16, 1'b0, 1'b1, 1'b0, 1'b0);
    run_packet(8, 1'b1, 1'b1, 1'b0, 1'b1);
    check_frames("bad_fcs_drop");
    @(posedge clk);
    pass_bad_fcs <= 1'b1;
    run_packet(16, 1'b0, 1'b1, 1'b0, 1'b1);
    check_frames("bad_fcs_pass");
    @(posedge clk);
    pass_bad_fcs <= 1'b0;
endtask

task automatic test_ignored_headers();
    run_packet(10, 1'b1, 1'b1, 1'b1, 1'b0);
    run_packet(10, 1'b1, 1'b0, 1'b0, 1'b0);
    run_packet(5, 1'b1, 1'b1, 1'b0, 1'b1);
    check_frames("ignored_headers");
endtask

task automatic test_back_pressure();
    ready_random = 1'b1;
    run_packet(20, 1'b1, 1'b1, 1'b0, 1'b1);
    run_packet(9, 1'b1, 1'b1, 1'b0, 1'b1);
    run_packet(33, 1'b1, 1'b1, 1'b0, 1'b1);
    check_frames("back_pressure");
    ready_random = 1'b0;
endtask

task automatic test_interrupt_count();
    // let any stray word or late pulse show up
    repeat (50) @(posedge clk);
    check_value("interrupt_count stray words", 64'(0), 64'(out_q.size()));
    check_value("interrupt_count tlast frames", 64'(frame_cnt), 64'(tlast_cnt));
    check_value("interrupt_count pulses", 64'(tlast_cnt), 64'(intr_cnt));
endtask

`endif

/* tests/tb_rx_intf.sv */
// testbench for the rx interface, drives decoder events and checks the framed word stream
`timescale 1ns/1ps

module tb_rx_intf;
    import rx_intf_pkg::*;

    // bytes driven over all tests, sizes the watchdog
    localparam int driven_bytes    = (1 + 8 + 13 + 100) + (16 + 8 + 16) + (10 + 10 + 5) +
                                     (20 + 9 + 33);
    localparam int watchdog_cycles = driven_bytes * 40 + 2000;

    logic                clk = 1'b0;
    logic                reset;
    logic                pkt_header_valid_strobe;
    logic                pkt_header_valid;
    logic                ht_unsupport;
    logic [rate_w-1:0]   pkt_rate;
    logic [len_w-1:0]    pkt_len;
    logic [rssi_w-1:0]   rssi_half_db;
    logic [tsf_w-1:0]    tsf_runtime_val;
    logic [byte_w-1:0]   byte_in;
    logic                byte_in_strobe;
    logic                fcs_in_strobe;
    logic                fcs_ok;
    logic                pass_bad_fcs;
    logic [word_w-1:0]   m_axis_tdata;
    logic                m_axis_tvalid;
    logic                m_axis_tlast;
    logic                m_axis_tready;
    logic                rx_pkt_intr;

    int                  seed = 32'h3f6cd4be;
    int                  ready_seed;
    logic                ready_random = 1'b0;
    int                  err_cnt = 0;

    // payload of the packet being sent
    logic [7:0]          pay [0:127];

    // expected and observed words
    logic [63:0]         exp_q [$];
    bit                  exp_last [$];
    logic [63:0]         out_q [$];
    bit                  last_q [$];
    logic [15:0]         exp_sn = '0;
    int                  frame_cnt = 0;
    int                  tlast_cnt = 0;
    int                  intr_cnt = 0;
    logic                prev_last_hs = 1'b0;

    `include "tb_tasks.svh"

    rx_intf_top dut_i (
        .clk                     (clk),
        .reset                   (reset),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .pkt_header_valid        (pkt_header_valid),
        .ht_unsupport            (ht_unsupport),
        .pkt_rate                (pkt_rate),
        .pkt_len                 (pkt_len),
        .rssi_half_db            (rssi_half_db),
        .tsf_runtime_val         (tsf_runtime_val),
        .byte_in                 (byte_in),
        .byte_in_strobe          (byte_in_strobe),
        .fcs_in_strobe           (fcs_in_strobe),
        .fcs_ok                  (fcs_ok),
        .pass_bad_fcs            (pass_bad_fcs),
        .m_axis_tdata            (m_axis_tdata),
        .m_axis_tvalid           (m_axis_tvalid),
        .m_axis_tlast            (m_axis_tlast),
        .m_axis_tready           (m_axis_tready),
        .rx_pkt_intr             (rx_pkt_intr)
    );

    always #2 clk = ~clk;

    // tready pattern, random only during the back-pressure test
    always @(posedge clk)
    begin
        if (ready_random)
            m_axis_tready <= (($random(ready_seed) & 3) != 0);
        else
            m_axis_tready <= 1'b1;
    end

    // output monitor
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (rx_pkt_intr)
            begin
                intr_cnt = intr_cnt + 1;
                check_value("interrupt after tlast", 64'(1), 64'(prev_last_hs));
            end
            prev_last_hs = m_axis_tvalid && m_axis_tready && m_axis_tlast;
            if (m_axis_tvalid && m_axis_tready)
            begin
                out_q.push_back(m_axis_tdata);
                last_q.push_back(m_axis_tlast);
                if (m_axis_tlast)
                    tlast_cnt = tlast_cnt + 1;
            end
        end
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the output stream did not deliver all frames in %0d cycles",
                 watchdog_cycles);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        // tready runs on its own random stream
        ready_seed              = ~seed;
        reset                   = 1'b1;
        pkt_header_valid_strobe = 1'b0;
        pkt_header_valid        = 1'b0;
        ht_unsupport            = 1'b0;
        pkt_rate                = '0;
        pkt_len                 = '0;
        rssi_half_db            = '0;
        tsf_runtime_val         = '0;
        byte_in                 = '0;
        byte_in_strobe          = 1'b0;
        fcs_in_strobe           = 1'b0;
        fcs_ok                  = 1'b0;
        pass_bad_fcs            = 1'b0;
        m_axis_tready           = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        test_good_packets();
        test_bad_fcs();
        test_ignored_headers();
        test_back_pressure();
        test_interrupt_count();
        if (err_cnt == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+tests
rtl/rx_intf_pkg.sv
rtl/rx_byte_if.sv
rtl/rx_word_if.sv
rtl/rx_event_capture.sv
rtl/byte_packer.sv
rtl/frame_buffer.sv
rtl/stream_out.sv
rtl/rx_intf_top.sv
tests/tb_rx_intf.sv

/* run_sim.sh */
#!/bin/sh
# build the rx interface testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_rx_intf --Mdir obj_dir -o sim_rx_intf

result=$(./obj_dir/sim_rx_intf || true)
echo "$result"
echo "$result" | grep -q "ALL TESTS PASSED"
